//--- design/memArb_params.svh
`ifndef MEMARB_PARAMS_SVH
`define MEMARB_PARAMS_SVH

// memory side widths
`define BLK_BITS 512
`define ADDR_BITS 32
`define BLK_BYTES_LOG2 6       // blocks sit on 64-byte boundaries

// accelerator signal table
`define SIG_NUM_BITS 4
`define SIG_TABLE_DEPTH 16
`define BLK_NUM_BITS 18

// byte address of block zero in the signal region
`define SIG_REGION_BASE 32'h1000_0000

`endif

//--- design/memArbPkg.sv
`default_nettype none

`include "memArb_params.svh"

package memArbPkg;

    typedef logic [`ADDR_BITS-1:0] addrT;        // byte address
    typedef logic [`BLK_BITS-1:0] blkT;          // one 64-byte block
    typedef logic [`BLK_NUM_BITS-1:0] blkNumT;   // block number inside the signal region
    typedef logic [`SIG_NUM_BITS-1:0] sigNumT;   // signal table index

    // opcode as the memory controller decodes it
    typedef enum logic [1:0] {
        opIdle  = 2'b00,
        opRead  = 2'b01,
        opWrite = 2'b11
    } memOpT;

    typedef enum logic [1:0] {
        arbIdle,        // waiting for a request, also the done cycle
        arbIssue,       // op on the bus until txDone
        arbWaitData     // read accepted, waiting for rdValid
    } arbStateT;

endpackage

`default_nettype wire

//--- design/memPortIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

// one requester to arbiter link
interface memPortIf import memArbPkg::*; ();

    logic req;      // level, held until done
    logic write;    // 1 = write wrBlk, 0 = read
    addrT addr;     // block aligned
    blkT  wrBlk;
    blkT  rdBlk;    // valid with done on a read
    logic done;     // single-cycle end of transaction

    modport requester (output req, write, addr, wrBlk, input rdBlk, done);
    modport arbiter (input req, write, addr, wrBlk, output rdBlk, done);

endinterface

`default_nettype wire

//--- design/instrFetchPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module instrFetchPort import memArbPkg::*; (
    input  wire       accelWrBlkDone,
    input  wire       accelRdBlkDone,
    input  wire       instrBlkReq,      // i-cache miss level
    input  wire addrT instrAddr,
    output blkT       instrBlk,
    output logic      instrBlkValid,
    memPortIf.requester bus
);

    logic armed;    // low until the miss request falls again
    logic take;
    addrT addrQ;

    // instruction side only ever reads
    assign bus.write = 1'b0;
    assign bus.wrBlk = '0;
    assign bus.addr  = addrQ;

    assign take = !bus.req && armed && instrBlkReq;

    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            bus.req       <= 1'b0;
            armed         <= 1'b1;
            instrBlkValid <= 1'b0;
        end else begin
            instrBlkValid <= bus.done;  // one cycle behind done
            if (!instrBlkReq)
                armed <= 1'b1;          // rearm on falling request
            if (bus.done) begin
                bus.req <= 1'b0;
            end else if (take) begin
                bus.req <= 1'b1;
                armed   <= 1'b0;
            end
        end
    end

    always_ff @(posedge accelWrBlkDone) begin
        if (take)
            addrQ <= {instrAddr[`ADDR_BITS-1:`BLK_BYTES_LOG2], {`BLK_BYTES_LOG2{1'b0}}};
        if (bus.done)
            instrBlk <= bus.rdBlk;      // fill block for the cache
    end

endmodule

`default_nettype wire

//--- design/dataCachePort.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module dataCachePort import memArbPkg::*; (
    input  wire       accelWrBlkDone,
    input  wire       accelRdBlkDone,
    input  wire       dataBlkReq,       // fill request
    input  wire       dataEvictReq,     // write-back request
    input  wire addrT dataAddr,
    input  wire blkT  dataBlkIn,        // victim block
    output blkT       dataBlk,
    output logic      dataBlkValid,
    output logic      dataEvictAck,
    memPortIf.requester bus
);

    logic evictArmed;
    logic fillArmed;
    logic takeEvict;
    logic takeFill;
    logic writeQ;
    addrT addrQ;
    blkT  wrBlkQ;

    assign bus.write = writeQ;
    assign bus.addr  = addrQ;
    assign bus.wrBlk = wrBlkQ;

    // eviction goes first, the fill waits behind it
    assign takeEvict = !bus.req && evictArmed && dataEvictReq;
    assign takeFill  = !bus.req && fillArmed && dataBlkReq && !takeEvict;

    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            bus.req      <= 1'b0;
            writeQ       <= 1'b0;
            evictArmed   <= 1'b1;
            fillArmed    <= 1'b1;
            dataBlkValid <= 1'b0;
            dataEvictAck <= 1'b0;
        end else begin
            dataEvictAck <= bus.done & writeQ;
            dataBlkValid <= bus.done & ~writeQ;
            if (!dataEvictReq)
                evictArmed <= 1'b1;
            if (!dataBlkReq)
                fillArmed <= 1'b1;
            if (bus.done) begin
                bus.req <= 1'b0;        // falls the cycle after done
            end else if (takeEvict) begin
                bus.req    <= 1'b1;
                writeQ     <= 1'b1;
                evictArmed <= 1'b0;
            end else if (takeFill) begin
                bus.req   <= 1'b1;
                writeQ    <= 1'b0;
                fillArmed <= 1'b0;
            end
        end
    end

    always_ff @(posedge accelWrBlkDone) begin
        if (takeEvict || takeFill)
            addrQ <= {dataAddr[`ADDR_BITS-1:`BLK_BYTES_LOG2], {`BLK_BYTES_LOG2{1'b0}}};
        if (takeEvict)
            wrBlkQ <= dataBlkIn;        // victim held for the whole write
        if (bus.done && !writeQ)
            dataBlk <= bus.rdBlk;
    end

endmodule

`default_nettype wire

//--- design/accelBufferPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module accelBufferPort import memArbPkg::*; (
    input  wire         accelWrBlkDone,
    input  wire         accelRdBlkDone,
    input  wire         tblWr,              // table load strobe
    input  wire sigNumT tblSigNum,
    input  wire blkNumT tblStartBlk,
    input  wire blkNumT tblEndBlk,
    input  wire         accelRd,            // host to buffer burst
    input  wire         accelWr,            // buffer to host burst
    input  wire sigNumT sigNum,
    input  wire blkT    accelBlkIn,
    output blkT         accelBlkOut,
    output logic        accelRdAck,
    output logic        accelWrAck,
    output logic        transformDone,
    memPortIf.requester bus
);

    // signal table, start and end block per signal
    blkNumT startTbl [`SIG_TABLE_DEPTH];
    blkNumT endTbl [`SIG_TABLE_DEPTH];

    blkNumT cursor;     // block in flight
    blkNumT endBlk;     // last block of the burst, inclusive
    logic   armed;
    logic   start;
    logic   lastBlk;
    logic   writeQ;
    blkT    wrBlkQ;

    assign start   = !bus.req && armed && (accelRd || accelWr);
    assign lastBlk = (cursor == endBlk);

    assign bus.write = writeQ;
    assign bus.wrBlk = wrBlkQ;
    assign bus.addr  = `SIG_REGION_BASE + (addrT'(cursor) << `BLK_BYTES_LOG2);

    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            bus.req       <= 1'b0;
            armed         <= 1'b1;
            writeQ        <= 1'b0;
            cursor        <= '0;
            accelRdAck    <= 1'b0;
            accelWrAck    <= 1'b0;
            transformDone <= 1'b0;
        end else begin
            accelRdAck    <= bus.done & ~writeQ;
            accelWrAck    <= bus.done & writeQ;
            transformDone <= bus.done & lastBlk;    // lines up with the final ack
            if (!accelRd && !accelWr)
                armed <= 1'b1;
            if (start) begin
                bus.req <= 1'b1;
                armed   <= 1'b0;
                writeQ  <= !accelRd;                // read wins if both raised
                cursor  <= startTbl[sigNum];
            end else if (bus.done) begin
                if (lastBlk)
                    bus.req <= 1'b0;                // burst finished
                else
                    cursor <= cursor + 1'b1;        // req stays up for the next block
            end
        end
    end

    always_ff @(posedge accelWrBlkDone) begin
        if (tblWr) begin
            startTbl[tblSigNum] <= tblStartBlk;
            endTbl[tblSigNum]   <= tblEndBlk;
        end
        if (start) begin
            endBlk <= endTbl[sigNum];
            wrBlkQ <= accelBlkIn;                   // first block of a write burst
        end else if (accelWrAck) begin
            wrBlkQ <= accelBlkIn;   // next block shown alongside the ack, ready before issue
        end
        if (bus.done && !writeQ)
            accelBlkOut <= bus.rdBlk;
    end

endmodule

`default_nettype wire

//--- design/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module memArbiter import memArbPkg::*; (
    input  wire       accelWrBlkDone,
    input  wire       accelRdBlkDone,
    memPortIf.arbiter instrBus,
    memPortIf.arbiter dataBus,
    memPortIf.arbiter accelBus,
    output memOpT     op,
    output addrT      ioAddr,
    output blkT       busOut,
    input  wire blkT  busIn,
    input  wire       txDone,
    input  wire       rdValid
);

    arbStateT   state;
    logic [2:0] reqVec;     // {accel, data, instr}
    logic [2:0] grantQ;     // one-hot, same order
    logic       doneQ;
    logic       selWrite;
    blkT        rdBlkQ;

    assign reqVec = {accelBus.req, dataBus.req, instrBus.req};

    // granted port drives the controller, requester holds it steady
    always_comb begin
        ioAddr   = '0;
        busOut   = '0;
        selWrite = 1'b0;
        if (grantQ[2]) begin
            ioAddr   = accelBus.addr;
            busOut   = accelBus.wrBlk;
            selWrite = accelBus.write;
        end else if (grantQ[1]) begin
            ioAddr   = dataBus.addr;
            busOut   = dataBus.wrBlk;
            selWrite = dataBus.write;
        end else if (grantQ[0]) begin
            ioAddr   = instrBus.addr;
            busOut   = instrBus.wrBlk;
            selWrite = instrBus.write;
        end
    end

    assign op = (state == arbIssue) ? (selWrite ? opWrite : opRead) : opIdle;

    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            state  <= arbIdle;
            grantQ <= '0;
            doneQ  <= 1'b0;
        end else begin
            doneQ <= 1'b0;  // pulse
            case (state)
                arbIdle: begin
                    // skip the done cycle, the finished req is still up
                    if (!doneQ && (|reqVec)) begin
                        if (reqVec[2])
                            grantQ <= 3'b100;
                        else if (reqVec[1])
                            grantQ <= 3'b010;
                        else
                            grantQ <= 3'b001;
                        state <= arbIssue;
                    end
                end
                arbIssue: begin
                    if (txDone) begin
                        if (selWrite) begin
                            doneQ <= 1'b1;          // write ends at txDone
                            state <= arbIdle;
                        end else begin
                            state <= arbWaitData;
                        end
                    end
                end
                arbWaitData: begin
                    if (rdValid) begin
                        doneQ <= 1'b1;
                        state <= arbIdle;
                    end
                end
                default: state <= arbIdle;
            endcase
        end
    end

    // read data captured on rdValid
    always_ff @(posedge accelWrBlkDone) begin
        if (state == arbWaitData && rdValid)
            rdBlkQ <= busIn;
    end

    // done and data back to the granted port only
    assign instrBus.done  = doneQ & grantQ[0];
    assign dataBus.done   = doneQ & grantQ[1];
    assign accelBus.done  = doneQ & grantQ[2];
    assign instrBus.rdBlk = grantQ[0] ? rdBlkQ : '0;
    assign dataBus.rdBlk  = grantQ[1] ? rdBlkQ : '0;
    assign accelBus.rdBlk = grantQ[2] ? rdBlkQ : '0;

endmodule

`default_nettype wire

//--- design/memArbTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module memArbTop import memArbPkg::*; (
    input  wire         accelWrBlkDone,     // clock
    input  wire         accelRdBlkDone,     // async reset, active high
    // instruction cache
    input  wire         instrBlkReq,
    input  wire addrT   instrAddr,
    output wire blkT    instrBlk,
    output wire         instrBlkValid,
    // data cache
    input  wire         dataBlkReq,
    input  wire         dataEvictReq,
    input  wire addrT   dataAddr,
    input  wire blkT    dataBlkIn,
    output wire blkT    dataBlk,
    output wire         dataBlkValid,
    output wire         dataEvictAck,
    // accelerator buffer and signal table
    input  wire         tblWr,
    input  wire sigNumT tblSigNum,
    input  wire blkNumT tblStartBlk,
    input  wire blkNumT tblEndBlk,
    input  wire         accelRd,
    input  wire         accelWr,
    input  wire sigNumT sigNum,
    input  wire blkT    accelBlkIn,
    output wire blkT    accelBlkOut,
    output wire         accelRdAck,
    output wire         accelWrAck,
    output wire         transformDone,
    // memory controller
    output wire memOpT  op,
    output wire addrT   ioAddr,
    output wire blkT    busOut,
    input  wire blkT    busIn,
    input  wire         txDone,
    input  wire         rdValid
);

    memPortIf instrBus ();
    memPortIf dataBus ();
    memPortIf accelBus ();

    instrFetchPort instrPort_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .instrBlkReq    (instrBlkReq),
        .instrAddr      (instrAddr),
        .instrBlk       (instrBlk),
        .instrBlkValid  (instrBlkValid),
        .bus            (instrBus.requester)
    );

    dataCachePort dataPort_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .dataBlkReq     (dataBlkReq),
        .dataEvictReq   (dataEvictReq),
        .dataAddr       (dataAddr),
        .dataBlkIn      (dataBlkIn),
        .dataBlk        (dataBlk),
        .dataBlkValid   (dataBlkValid),
        .dataEvictAck   (dataEvictAck),
        .bus            (dataBus.requester)
    );

    accelBufferPort accelPort_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .tblWr          (tblWr),
        .tblSigNum      (tblSigNum),
        .tblStartBlk    (tblStartBlk),
        .tblEndBlk      (tblEndBlk),
        .accelRd        (accelRd),
        .accelWr        (accelWr),
        .sigNum         (sigNum),
        .accelBlkIn     (accelBlkIn),
        .accelBlkOut    (accelBlkOut),
        .accelRdAck     (accelRdAck),
        .accelWrAck     (accelWrAck),
        .transformDone  (transformDone),
        .bus            (accelBus.requester)
    );

    memArbiter arbiter_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .instrBus       (instrBus.arbiter),
        .dataBus        (dataBus.arbiter),
        .accelBus       (accelBus.arbiter),
        .op             (op),
        .ioAddr         (ioAddr),
        .busOut         (busOut),
        .busIn          (busIn),
        .txDone         (txDone),
        .rdValid        (rdValid)
    );

endmodule

`default_nettype wire

//--- verification/memArb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module memArbAsserts import memArbPkg::*; (
    input wire        accelWrBlkDone,
    input wire        accelRdBlkDone,
    input wire memOpT op,
    input wire addrT  ioAddr,
    input wire blkT   busOut,
    input wire        txDone,
    input wire        instrBlkValid,
    input wire        dataBlkValid,
    input wire        dataEvictAck,
    input wire        accelRdAck,
    input wire        accelWrAck,
    input wire        transformDone
);

    logic [5:0] pulses;
    assign pulses = {instrBlkValid, dataBlkValid, dataEvictAck, accelRdAck, accelWrAck,
                     transformDone};

    // controller request frozen until txDone
    opHeld: assert property (@(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        (op != opIdle && !txDone) |=>
            (op == $past(op) && ioAddr == $past(ioAddr) && busOut == $past(busOut)))
        else $error("op, ioAddr or busOut changed before txDone");

    opRelease: assert property (@(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        (op != opIdle && txDone) |=> op == opIdle)   // bus freed once taken
        else $error("op still active after txDone");

    genvar i;
    for (i = 0; i < 6; i++) begin : pulseCheck
        onePulse: assert property (@(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
            pulses[i] |=> !pulses[i])
            else $error("output pulse %0d held longer than one cycle", i);
    end

    // quiet bus and outputs in the cycle after reset
    idleAfterReset: assert property (@(posedge accelWrBlkDone)
        accelRdBlkDone |=> (op == opIdle && pulses == '0))
        else $error("outputs not idle after reset");

endmodule

bind memArbTop memArbAsserts asserts_i (
    .accelWrBlkDone (accelWrBlkDone),
    .accelRdBlkDone (accelRdBlkDone),
    .op             (op),
    .ioAddr         (ioAddr),
    .busOut         (busOut),
    .txDone         (txDone),
    .instrBlkValid  (instrBlkValid),
    .dataBlkValid   (dataBlkValid),
    .dataEvictAck   (dataEvictAck),
    .accelRdAck     (accelRdAck),
    .accelWrAck     (accelWrAck),
    .transformDone  (transformDone)
);

`default_nettype wire

//--- verification/memArbTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_params.svh"

module memArbTb import memArbPkg::*; ();

    localparam int timeoutCycles = 100;     // per wait

    logic   accelWrBlkDone;                 // clock
    logic   accelRdBlkDone;                 // reset
    logic   instrBlkReq, dataBlkReq, dataEvictReq, tblWr, accelRd, accelWr;
    logic   instrBlkValid, dataBlkValid, dataEvictAck, accelRdAck, accelWrAck, transformDone;
    logic   txDone, rdValid;
    addrT   instrAddr, dataAddr, ioAddr;
    blkT    dataBlkIn, accelBlkIn, busIn, instrBlk, dataBlk, accelBlkOut, busOut;
    sigNumT tblSigNum, sigNum;
    blkNumT tblStartBlk, tblEndBlk;
    memOpT  op;
    logic [5:0] pulseVec;                   // {done, wrAck, rdAck, evictAck, dataValid, instrValid}
    int     pulseCount [6] = '{0, 0, 0, 0, 0, 0};
    int     seed = 65156;
    blkT    mem [addrT];                    // blocks written through the controller
    addrT   opLog [$];                      // ioAddr of each transaction in order

    memArbTop dut_i (.*);

    assign pulseVec = {transformDone, accelWrAck, accelRdAck, dataEvictAck, dataBlkValid,
                       instrBlkValid};

    initial begin
        accelWrBlkDone = 1'b0;
        forever #4 accelWrBlkDone = ~accelWrBlkDone;    // 8 ns period
    end

    // tally of every output pulse
    always @(negedge accelWrBlkDone)
        for (int i = 0; i < 6; i++)
            if (pulseVec[i])
                pulseCount[i]++;

    // unwritten memory reads back its own address
    function automatic blkT patternBlk(input addrT a);
        return {(`BLK_BITS / `ADDR_BITS){a}};
    endfunction

    function automatic addrT sigBlkAddr(input int b);
        return `SIG_REGION_BASE + addrT'(b) * 64;      // 64-byte blocks
    endfunction

    function automatic blkT randBlk();
        blkT b;
        for (int i = 0; i < `BLK_BITS / 32; i++)
            b[i*32 +: 32] = $random(seed);
        return b;
    endfunction

    task automatic abortRun();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input blkT expected, input blkT actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    // returns on the negedge where the pulse is seen
    task automatic waitFor(input int idx, input string name);
        int cycles;
        cycles = 0;
        @(negedge accelWrBlkDone);
        while (!pulseVec[idx]) begin
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("Timeout at %0t ns, %s never pulsed", $time, name);
                abortRun();
            end
            @(negedge accelWrBlkDone);
        end
    endtask

    task automatic loadEntry(input sigNumT s, input blkNumT first, input blkNumT last);
        tblSigNum   = s;
        tblStartBlk = first;
        tblEndBlk   = last;
        tblWr       = 1'b1;
        @(negedge accelWrBlkDone);
        tblWr = 1'b0;
    endtask

    // memory controller model
    initial begin : memModel
        addrT  a;
        memOpT o;
        blkT   d;
        int    n;
        txDone  = 1'b0;
        rdValid = 1'b0;
        busIn   = '0;
        forever begin
            @(negedge accelWrBlkDone);
            if (op != opIdle) begin
                a = ioAddr;
                o = op;
                d = busOut;
                opLog.push_back(a);
                n = 1 + ($random(seed) & 3);        // 1 to 4 cycles to txDone
                repeat (n) @(negedge accelWrBlkDone);
                txDone = 1'b1;
                if (o == opWrite)
                    mem[a] = d;
                @(negedge accelWrBlkDone);
                txDone = 1'b0;
                if (o == opRead) begin
                    n = 1 + ({$random(seed)} % 3);  // data 1 to 3 cycles after txDone
                    repeat (n - 1) @(negedge accelWrBlkDone);
                    busIn   = mem.exists(a) ? mem[a] : patternBlk(a);
                    rdValid = 1'b1;
                    @(negedge accelWrBlkDone);
                    rdValid = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        blkT  victim;
        blkT  wrBlks [3];
        addrT orderExp [3];
        int   expCount [6];
        int   logStart;
        accelRdBlkDone = 1'b1;
        instrBlkReq    = 1'b0;
        dataBlkReq     = 1'b0;
        dataEvictReq   = 1'b0;
        tblWr          = 1'b0;
        accelRd        = 1'b0;
        accelWr        = 1'b0;
        instrAddr      = '0;
        dataAddr       = '0;
        dataBlkIn      = '0;
        accelBlkIn     = '0;
        tblSigNum      = '0;
        tblStartBlk    = '0;
        tblEndBlk      = '0;
        sigNum         = '0;
        repeat (2) @(negedge accelWrBlkDone);
        accelRdBlkDone = 1'b0;

        repeat (3) begin                    // quiet until the first request
            @(negedge accelWrBlkDone);
            checkEq("op", blkT'(opIdle), blkT'(op));
            checkEq("valid and ack outputs", '0, blkT'(pulseVec));
        end

        instrAddr   = 32'h0000_1234;        // unaligned miss
        instrBlkReq = 1'b1;
        waitFor(0, "instrBlkValid");
        checkEq("instrBlk", patternBlk(32'h0000_1200), instrBlk);
        instrBlkReq = 1'b0;

        victim       = randBlk();
        dataAddr     = 32'h0000_2345;
        dataBlkIn    = victim;
        dataEvictReq = 1'b1;
        waitFor(2, "dataEvictAck");
        dataEvictReq = 1'b0;
        checkEq("memory at 0x2340", victim, mem[32'h0000_2340]);
        dataAddr   = 32'h0000_2370;         // same block, other offset
        dataBlkReq = 1'b1;
        waitFor(1, "dataBlkValid");
        dataBlkReq = 1'b0;
        checkEq("dataBlk", victim, dataBlk);

        loadEntry(4'd3, 18'd5, 18'd8);
        loadEntry(4'd7, 18'd20, 18'd22);
        loadEntry(4'd9, 18'd40, 18'd40);    // single block signal

        sigNum  = 4'd3;
        accelRd = 1'b1;
        for (int b = 5; b <= 8; b++) begin
            waitFor(3, "accelRdAck");
            checkEq("accelBlkOut", patternBlk(sigBlkAddr(b)), accelBlkOut);
            checkEq("transformDone", blkT'(b == 8), blkT'(transformDone));
        end
        accelRd = 1'b0;
        @(negedge accelWrBlkDone);          // one idle cycle rearms the accelerator port

        foreach (wrBlks[i])
            wrBlks[i] = randBlk();
        sigNum     = 4'd7;
        accelBlkIn = wrBlks[0];
        accelWr    = 1'b1;
        for (int i = 0; i < 3; i++) begin
            waitFor(4, "accelWrAck");
            checkEq("transformDone", blkT'(i == 2), blkT'(transformDone));
            accelBlkIn = wrBlks[(i + 1) % 3];   // next block rides with the ack
        end
        accelWr = 1'b0;
        @(negedge accelWrBlkDone);
        for (int i = 0; i < 3; i++)
            checkEq($sformatf("memory at block %0d", 20 + i), wrBlks[i], mem[sigBlkAddr(20 + i)]);

        logStart    = opLog.size();
        instrAddr   = 32'h0000_3000;
        dataAddr    = 32'h0000_4000;
        sigNum      = 4'd9;
        instrBlkReq = 1'b1;                 // all three in one cycle
        dataBlkReq  = 1'b1;
        accelRd     = 1'b1;
        waitFor(3, "accelRdAck");
        waitFor(1, "dataBlkValid");
        waitFor(0, "instrBlkValid");
        instrBlkReq = 1'b0;
        dataBlkReq  = 1'b0;
        accelRd     = 1'b0;
        checkEq("accelBlkOut", patternBlk(sigBlkAddr(40)), accelBlkOut);
        checkEq("dataBlk", patternBlk(32'h0000_4000), dataBlk);
        checkEq("instrBlk", patternBlk(32'h0000_3000), instrBlk);
        orderExp = '{sigBlkAddr(40), 32'h0000_4000, 32'h0000_3000};
        foreach (orderExp[i])
            checkEq($sformatf("ioAddr of transaction %0d", i), blkT'(orderExp[i]),
                    blkT'(opLog[logStart + i]));

        repeat (4) @(negedge accelWrBlkDone);
        expCount = '{2, 2, 1, 5, 3, 3};     // same order as pulseVec bits
        foreach (expCount[i])
            checkEq($sformatf("pulse count %0d", i), blkT'(expCount[i]), blkT'(pulseCount[i]));
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/memArbPkg.sv
design/memPortIf.sv
design/instrFetchPort.sv
design/dataCachePort.sv
design/accelBufferPort.sv
design/memArbiter.sv
design/memArbTop.sv
verification/memArb_asserts.sv
verification/memArbTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory arbiter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module memArbTb -Mdir "$buildDir" -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/VmemArbTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Testbench passed" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1
